// ==== axi_pkg.sv ====
package axi_pkg;

    // AR channel field types
    typedef logic [1:0] axi_burst_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;

    // One line refill is eight beats of 8 bytes
    localparam axi_len_t   axi_len_line   = 8'd7;  // Beats minus one
    localparam axi_size_t  axi_size_dword = 3'd3;  // 2**3 bytes per beat

    // Linear burst from a line-aligned address
    localparam axi_burst_t axi_burst_incr = 2'b01;

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

    // Bus widths
    localparam int addr_width = 64;
    localparam int data_width = 64;

    // Geometry
    localparam int line_bytes     = 64;                    // Bytes per line
    localparam int beats_per_line = line_bytes / (data_width / 8); // Words per line
    localparam int num_sets       = 4;
    localparam int num_ways       = 4;

    // Address split into tag, index and offset
    localparam int offset_width   = $clog2(line_bytes);    // Byte offset in a line
    localparam int word_sel_width = $clog2(beats_per_line);
    localparam int index_width    = $clog2(num_sets);
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int way_width      = $clog2(num_ways);

    typedef logic [data_width-1:0]     word_t;
    typedef logic [tag_width-1:0]      tag_t;
    typedef logic [index_width-1:0]    set_index_t;
    typedef logic [way_width-1:0]      way_t;
    typedef logic [word_sel_width-1:0] word_sel_t;

    // Request FSM of the controller
    typedef enum logic [1:0] {
        st_idle    = 2'd0, // Waiting for req
        st_lookup  = 2'd1, // Tag compare on the registered address
        st_refill  = 2'd2, // Line fetch in progress
        st_respond = 2'd3  // Ack held until req falls
    } ctrl_state_t;

endpackage

// ==== dcache_control.sv ====
`timescale 1ns/1ps

module dcache_control import cache_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    // CPU side
    input  logic                  req,
    input  logic                  write,
    input  logic [addr_width-1:0] address,
    input  word_t                 wdata,
    output logic                  ack,
    output logic [addr_width-1:0] req_address,
    output word_t                 req_wdata,
    // Tag array
    output set_index_t            lookup_index,
    output tag_t                  lookup_tag,
    output word_sel_t             word_sel,
    input  logic                  hit,
    input  logic                  set_full,
    input  way_t                  hit_way,
    input  way_t                  free_way,
    output logic                  install,
    // Data array
    output way_t                  access_way,
    output logic                  cpu_write,
    // Refill engine
    output logic                  refill_start,
    input  logic                  refill_done
);

    ctrl_state_t state;
    logic        req_write;          // Registered write flag
    way_t        victim;             // Way chosen on a miss
    way_t        victim_way;         // Victim kept for the whole refill
    way_t        rr_ptr [num_sets];  // Round-robin replacement pointer per set
    logic        miss;

    // Address fields of the held request
    assign lookup_index = req_address[offset_width +: index_width];
    assign lookup_tag   = req_address[addr_width-1 -: tag_width];
    assign word_sel     = req_address[offset_width-1 -: word_sel_width];

    assign miss   = (state == st_lookup) && !hit;
    assign victim = set_full ? rr_ptr[lookup_index] : free_way; // Empty way first

    // Lookup hit picks the hit way, a miss installs into the victim
    always_comb begin
        case (state)
            st_lookup: access_way = hit ? hit_way : victim;
            st_refill: access_way = victim_way;
            default:   access_way = hit_way;
        endcase
    end

    assign refill_start = miss;
    assign install      = miss || ((state == st_refill) && refill_done); // Start and end of fill
    assign cpu_write    = (state == st_respond) && req_write && !ack;    // Lands with ack

    // Request registers, captured on accept
    always_ff @(posedge clock) begin
        if (state == st_idle && req && !ack) begin
            req_address <= address;
            req_wdata   <= wdata;
            req_write   <= write;
        end
        if (miss) begin
            victim_way <= victim;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= st_idle;
            ack    <= 1'b0;
            rr_ptr <= '{default: '0};
        end else begin
            case (state)
                st_idle: begin
                    if (req && !ack) begin
                        state <= st_lookup;          // Accept
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        state <= st_respond;
                    end else begin
                        state <= st_refill;
                        if (set_full) begin
                            rr_ptr[lookup_index] <= rr_ptr[lookup_index] + 1'b1; // Next victim
                        end
                    end
                end
                st_refill: begin
                    if (refill_done) begin
                        state <= st_lookup;          // Line now valid, look up again
                    end
                end
                st_respond: begin
                    if (!ack) begin
                        ack <= 1'b1;                 // Two cycles after lookup start
                    end else if (!req) begin
                        ack   <= 1'b0;               // Four-phase return to zero
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Ack only rises in answer to a live request
    a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        !ack && !req |=> !ack)
        else $error("control: ack rose with req low");

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array import cache_pkg::*; (
    input  logic       clock,
    input  set_index_t index,
    input  way_t       way,
    input  word_sel_t  word_sel,
    input  logic       cpu_write,
    input  word_t      cpu_wdata,
    input  logic       beat_write,
    input  word_sel_t  beat_sel,
    input  word_t      beat_data,
    output word_t      rdata
);

    // Eight words per line, each line at [set][way]
    word_t lines [num_sets][num_ways][beats_per_line];

    always_ff @(posedge clock) begin
        if (cpu_write) begin
            lines[index][way][word_sel] <= cpu_wdata;  // Store hit or merge after refill
        end else if (beat_write) begin
            lines[index][way][beat_sel] <= beat_data;  // Refill beat into victim way
        end
    end

    // Word read port
    assign rdata = lines[index][way][word_sel];

    // Control only writes in respond, refill only beats in refill
    a_write_exclusive: assert property (@(posedge clock)
        !(cpu_write && beat_write))
        else $error("data array: CPU write and refill beat in one cycle");

endmodule

// ==== dcache_refill.sv ====
`timescale 1ns/1ps

module dcache_refill import cache_pkg::*, axi_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [addr_width-1:0] line_address,
    output logic                  beat_write,
    output word_sel_t             beat_sel,
    output word_t                 beat_data,
    output logic                  done,
    // AXI read address channel
    output logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    output logic [addr_width-1:0] m_axi_araddr,
    output axi_len_t              m_axi_arlen,
    output axi_size_t             m_axi_arsize,
    output axi_burst_t            m_axi_arburst,
    // AXI read data channel
    input  logic                  m_axi_rvalid,
    output logic                  m_axi_rready,
    input  word_t                 m_axi_rdata,
    input  logic                  m_axi_rlast
);

    word_sel_t beat_count; // Next beat slot in the line

    // Burst fields, fixed for every refill
    assign m_axi_araddr  = {line_address[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign m_axi_arlen   = axi_len_line;
    assign m_axi_arsize  = axi_size_dword;
    assign m_axi_arburst = axi_burst_incr;

    // Each accepted beat goes straight to the data array
    assign beat_write = m_axi_rvalid && m_axi_rready;
    assign beat_sel   = beat_count;
    assign beat_data  = m_axi_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            beat_count    <= '0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;                                   // Single-cycle pulse
            if (start) begin
                m_axi_arvalid <= 1'b1;                      // Address phase next cycle
                beat_count    <= '0;
            end else if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
                m_axi_rready  <= 1'b1;                      // Open for data beats
            end else if (beat_write) begin
                beat_count <= beat_count + 1'b1;
                if (m_axi_rlast) begin
                    m_axi_rready <= 1'b0;
                    done         <= 1'b1;                   // One cycle after last beat
                end
            end
        end
    end

    // Memory must end the burst on beat eight
    a_rlast_eighth: assert property (@(posedge clock) disable iff (reset)
        beat_write |-> (m_axi_rlast == (beat_count == word_sel_t'(beats_per_line - 1))))
        else $error("refill: rlast on beat %0d", beat_count);

    // AR request held steady until taken
    a_ar_stable: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
        else $error("refill: AR request changed before arready");

endmodule

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array import cache_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  set_index_t lookup_index,
    input  tag_t       lookup_tag,
    input  logic       install,
    input  way_t       install_way,
    output logic       hit,
    output way_t       hit_way,
    output logic       set_full,
    output way_t       free_way
);

    tag_t                tags  [num_sets][num_ways]; // Tag storage
    logic [num_ways-1:0] valid [num_sets];           // One valid bit per way
    logic [num_ways-1:0] match;                      // Per-way tag hit
    logic                fill_pending;               // Between the two install strobes
    way_t                fill_way;                   // Way opened by the first strobe

    // Tag write on the first strobe of a fill
    always_ff @(posedge clock) begin
        if (install && !fill_pending) begin
            tags[lookup_index][install_way] <= lookup_tag;
            fill_way                        <= install_way;
        end
    end

    // Install comes twice per fill
    // First strobe drops valid while beats arrive, second one sets it
    always_ff @(posedge clock) begin
        if (reset) begin
            valid        <= '{default: '0};
            fill_pending <= 1'b0;
        end else if (install) begin
            valid[lookup_index][install_way] <= fill_pending;
            fill_pending <= !fill_pending;
        end
    end

    // Parallel compare over all ways of the set
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin // Downward so lowest way wins
            match[w] = valid[lookup_index][w] && (tags[lookup_index][w] == lookup_tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
            if (!valid[lookup_index][w]) begin
                free_way = way_t'(w);              // Lowest empty way
            end
        end
    end

    assign hit      = |match;
    assign set_full = &valid[lookup_index];         // No empty way left

    // A tag lives in one way of a set at most
    a_single_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(match))
        else $error("tag array: more than one way hits in set %0d", lookup_index);

    // Both strobes of one fill go to the same way
    a_install_way: assert property (@(posedge clock) disable iff (reset)
        install && fill_pending |-> install_way == fill_way)
        else $error("tag array: fill finished in a different way");

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import cache_pkg::*, axi_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    // CPU port, four-phase req/ack
    input  logic                  req,
    input  logic                  write,
    input  logic [addr_width-1:0] address,
    input  word_t                 wdata,
    output logic                  ack,
    output word_t                 rdata,
    // AXI read port for line refills
    output logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    output logic [addr_width-1:0] m_axi_araddr,
    output axi_len_t              m_axi_arlen,
    output axi_size_t             m_axi_arsize,
    output axi_burst_t            m_axi_arburst,
    input  logic                  m_axi_rvalid,
    output logic                  m_axi_rready,
    input  word_t                 m_axi_rdata,
    input  logic                  m_axi_rlast
);

    logic [addr_width-1:0] req_address;  // Held request address
    word_t                 req_wdata;
    set_index_t            lookup_index;
    tag_t                  lookup_tag;
    word_sel_t             word_sel;
    logic                  hit;
    logic                  set_full;
    way_t                  hit_way;
    way_t                  free_way;
    logic                  install;
    way_t                  access_way;    // Way for data access and install
    logic                  cpu_write;
    logic                  refill_start;
    logic                  refill_done;
    logic                  beat_write;
    word_sel_t             beat_sel;
    word_t                 beat_data;

    dcache_control u_control (
        .clock, .reset, .req, .write, .address, .wdata, .ack,
        .req_address, .req_wdata, .lookup_index, .lookup_tag, .word_sel,
        .hit, .set_full, .hit_way, .free_way, .install, .access_way,
        .cpu_write, .refill_start, .refill_done
    );

    dcache_tag_array u_tag_array (
        .clock, .reset, .lookup_index, .lookup_tag, .install,
        .install_way (access_way),
        .hit, .hit_way, .set_full, .free_way
    );

    dcache_data_array u_data_array (
        .clock,
        .index     (lookup_index),
        .way       (access_way),
        .word_sel,
        .cpu_write,
        .cpu_wdata (req_wdata),
        .beat_write, .beat_sel, .beat_data,
        .rdata
    );

    dcache_refill u_refill (
        .clock, .reset,
        .start        (refill_start),
        .line_address (req_address),
        .beat_write, .beat_sel, .beat_data,
        .done         (refill_done),
        .m_axi_arvalid, .m_axi_arready, .m_axi_araddr, .m_axi_arlen,
        .m_axi_arsize, .m_axi_arburst, .m_axi_rvalid, .m_axi_rready,
        .m_axi_rdata, .m_axi_rlast
    );

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem import cache_pkg::*, axi_pkg::*; #(
    parameter word_t data_key = '0          // XOR key of the memory contents
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_width-1:0] araddr,
    input  axi_len_t              arlen,
    input  axi_size_t             arsize,
    input  axi_burst_t            arburst,
    output logic                  rvalid,
    input  logic                  rready,
    output word_t                 rdata,
    output logic                  rlast,
    output logic [31:0]           ar_count,      // AR handshakes seen
    output logic                  protocol_error
);

    logic                  busy;       // Burst in progress
    logic [addr_width-1:0] base;       // Burst start address
    logic [3:0]            beat;       // Beat on the bus or next to show
    logic [3:0]            next_beat;

    always @(posedge clock) begin
        if (reset) begin
            arready        <= 1'b0;
            rvalid         <= 1'b0;
            rlast          <= 1'b0;
            rdata          <= '0;
            busy           <= 1'b0;
            base           <= '0;
            beat           <= '0;
            ar_count       <= '0;
            protocol_error <= 1'b0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                // A line refill is eight beats of 8 bytes, INCR, from a line boundary
                if (arlen != 8'd7 || arsize != 3'd3 || arburst != 2'b01) begin
                    $display("AXI slave: burst fields wrong, arlen %0d arsize %0d arburst %0d",
                             arlen, arsize, arburst);
                    protocol_error <= 1'b1;
                end
                if (araddr % line_bytes != 0) begin
                    $display("AXI slave: araddr %h is not on a line boundary", araddr);
                    protocol_error <= 1'b1;
                end
                ar_count <= ar_count + 1;
                base     <= araddr;
                beat     <= '0;
                busy     <= 1'b1;
                arready  <= 1'b0;
            end else begin
                arready <= ($urandom % 4) != 0;           // Stall about one cycle in four
            end
        end else if (!rvalid || rready) begin             // Beat taken or none shown
            if (rvalid && rlast) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                busy   <= 1'b0;                           // Burst done
            end else begin
                next_beat = rvalid ? beat + 1'b1 : beat;
                beat <= next_beat;
                if ($urandom % 4 == 0) begin
                    rvalid <= 1'b0;                       // Data gap
                end else begin
                    rvalid <= 1'b1;
                    rdata  <= word_t'(base + 8 * next_beat) ^ data_key;
                    rlast  <= (next_beat == 4'd7);
                end
            end
        end
    end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import cache_pkg::*, axi_pkg::*;
();

    localparam int    clock_period    = 40;
    localparam int    num_entries     = 17;
    localparam int    watchdog_cycles = num_entries * 300;
    localparam word_t data_key        = 64'hc0de_0000_0000_0000;

    typedef enum logic {op_read, op_write} op_t;

    logic clock, reset, req, write, ack;
    logic [addr_width-1:0] address, m_axi_araddr;
    word_t      wdata, rdata, m_axi_rdata;
    logic       m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
    axi_len_t   m_axi_arlen;
    axi_size_t  m_axi_arsize;
    axi_burst_t m_axi_arburst;
    logic [31:0] ar_count;
    logic        protocol_error;

    // Stimulus table, one access per row
    string                 entry_name  [num_entries];
    op_t                   entry_op    [num_entries];
    logic [addr_width-1:0] entry_addr  [num_entries];
    word_t                 entry_wdata [num_entries];
    word_t                 entry_rdata [num_entries]; // Unused for writes
    int                    entry_ar    [num_entries]; // AR count once acked
    int                    fill_index;

    dcache_top dut (
        .clock, .reset, .req, .write, .address, .wdata, .ack, .rdata,
        .m_axi_arvalid, .m_axi_arready, .m_axi_araddr, .m_axi_arlen, .m_axi_arsize,
        .m_axi_arburst, .m_axi_rvalid, .m_axi_rready, .m_axi_rdata, .m_axi_rlast
    );

    tb_axi_mem #(.data_key(data_key)) axi_mem (
        .clock, .reset, .arvalid(m_axi_arvalid), .arready(m_axi_arready),
        .araddr(m_axi_araddr), .arlen(m_axi_arlen), .arsize(m_axi_arsize),
        .arburst(m_axi_arburst), .rvalid(m_axi_rvalid), .rready(m_axi_rready),
        .rdata(m_axi_rdata), .rlast(m_axi_rlast), .ar_count, .protocol_error
    );

    // Memory word at a byte address
    function automatic word_t memory_word(input logic [addr_width-1:0] byte_addr);
        return byte_addr ^ data_key;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic add_entry(input string name, input op_t op, input logic [63:0] addr,
                             input word_t wdata_value, input word_t exp_rdata, input int exp_ar);
        entry_name[fill_index]  = name;
        entry_op[fill_index]    = op;
        entry_addr[fill_index]  = addr;
        entry_wdata[fill_index] = wdata_value;
        entry_rdata[fill_index] = exp_rdata;
        entry_ar[fill_index]    = exp_ar;
        fill_index++;
    endtask

    task automatic build_table();
        add_entry("rd_miss",    op_read,  64'h1000_0040, '0, memory_word(64'h1000_0040), 1);
        add_entry("rd_hit",     op_read,  64'h1000_0078, '0, memory_word(64'h1000_0078), 1);
        add_entry("wr_hit",     op_write, 64'h1000_0048, 64'h1111_2222_3333_4444, '0, 1);
        add_entry("rd_wr_hit",  op_read,  64'h1000_0048, '0, 64'h1111_2222_3333_4444, 1);
        add_entry("wr_miss",    op_write, 64'h2000_0090, 64'hdead_beef_0000_0001, '0, 2);
        add_entry("rd_wr_miss", op_read,  64'h2000_0090, '0, 64'hdead_beef_0000_0001, 2);
        add_entry("rd_nbr",     op_read,  64'h2000_0088, '0, memory_word(64'h2000_0088), 2);
        // Set 3 gets five lines, way 0 first
        add_entry("fill_a",     op_write, 64'h3000_00c8, 64'h5555_aaaa_5555_aaaa, '0, 3);
        add_entry("fill_b",     op_read,  64'h3001_00c0, '0, memory_word(64'h3001_00c0), 4);
        add_entry("fill_c",     op_read,  64'h3002_00c0, '0, memory_word(64'h3002_00c0), 5);
        add_entry("fill_d",     op_read,  64'h3003_00c0, '0, memory_word(64'h3003_00c0), 6);
        add_entry("fill_e",     op_read,  64'h3004_00c0, '0, memory_word(64'h3004_00c0), 7);
        add_entry("reread_a",   op_read,  64'h3000_00c8, '0, memory_word(64'h3000_00c8), 8);
        add_entry("hit_d",      op_read,  64'h3003_00f8, '0, memory_word(64'h3003_00f8), 8);
        add_entry("hit_e",      op_read,  64'h3004_00c0, '0, memory_word(64'h3004_00c0), 8);
        add_entry("miss_b",     op_read,  64'h3001_00c0, '0, memory_word(64'h3001_00c0), 9);
        add_entry("keep_set1",  op_read,  64'h1000_0048, '0, 64'h1111_2222_3333_4444, 9);
    endtask

    // One four-phase transfer
    task automatic run_entry(input int i);
        int hold;
        hold = $urandom_range(3, 0);
        @(posedge clock);
        req     <= 1'b1;
        write   <= (entry_op[i] == op_write);
        address <= entry_addr[i];
        wdata   <= entry_wdata[i];
        @(negedge clock);
        while (!ack) @(negedge clock);
        if (entry_op[i] == op_read) begin
            check_value({entry_name[i], ".rdata"}, entry_rdata[i], rdata);
        end
        check_value({entry_name[i], ".ar_count"}, word_t'(entry_ar[i]), word_t'(ar_count));
        repeat (hold) @(posedge clock);           // Stretch respond
        @(posedge clock);
        req <= 1'b0;
        @(negedge clock);
        check_value({entry_name[i], ".ack_hold"}, 64'd1, word_t'(ack)); // Still high after req falls
        if (entry_op[i] == op_read) begin
            check_value({entry_name[i], ".rdata_hold"}, entry_rdata[i], rdata);
        end
        @(negedge clock);
        check_value({entry_name[i], ".ack_drop"}, 64'd0, word_t'(ack));
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        abort_run($sformatf("Watchdog expired after %0d cycles without a result",
                            watchdog_cycles));
    end

    initial begin
        wait (protocol_error === 1'b1);
        abort_run("AXI slave model saw a malformed read burst");
    end

    initial begin
        void'($urandom(32'h8fcc_d147));
        reset      <= 1'b1;
        req        <= 1'b0;
        write      <= 1'b0;
        address    <= '0;
        wdata      <= '0;
        fill_index = 0;
        build_table();
        if (fill_index != num_entries) abort_run("Stimulus table row count is wrong");
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("reset.ack", 64'd0, word_t'(ack));
        check_value("reset.arvalid", 64'd0, word_t'(m_axi_arvalid));
        check_value("reset.rready", 64'd0, word_t'(m_axi_rready));
        for (int i = 0; i < num_entries; i++) run_entry(i);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
cache_pkg.sv
axi_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_refill.sv
dcache_control.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv
